//--- src/lsq_pkg.sv
package lsq_pkg;

  // Operation carried by the dispatch port, one per cycle
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_t;

  // Store drain state
  // DRAIN_WRITE holds while committed stores wait for the memory port
  typedef enum logic {
    DRAIN_IDLE  = 1'b0,
    DRAIN_WRITE = 1'b1
  } drain_state_t;

endpackage

//--- src/store_queue.sv
`timescale 1ns/1ps

module store_queue #(
  parameter int ADDR_WIDTH = 6,
  parameter int DATA_WIDTH = 32,
  parameter int SQ_DEPTH   = 8
) (
  input  logic                          clock,
  input  logic                          reset,
  input  lsq_pkg::mem_op_t              dispatch_op,
  input  logic                          store_exec,
  input  logic [$clog2(SQ_DEPTH)-1:0]   store_exec_idx,
  input  logic [ADDR_WIDTH-1:0]         store_addr,
  input  logic [DATA_WIDTH-1:0]         store_data,
  input  logic                          retire_store,
  input  logic [ADDR_WIDTH-1:0]         fwd_addr,
  input  logic [$clog2(SQ_DEPTH):0]     fwd_tag,
  input  logic                          wr_grant,
  output logic                          store_ready,
  output logic [$clog2(SQ_DEPTH)-1:0]   sq_idx,
  output logic [$clog2(SQ_DEPTH):0]     sq_tail,
  output logic                          fwd_hit,
  output logic [DATA_WIDTH-1:0]         fwd_data,
  output logic                          wr_req,
  output logic [ADDR_WIDTH-1:0]         wr_addr,
  output logic [DATA_WIDTH-1:0]         wr_data
);
  import lsq_pkg::*;

  localparam int IDX_WIDTH = $clog2(SQ_DEPTH);
  // Pointers carry one extra wrap bit so a load tag can tell a full queue from an empty one
  localparam int PTR_WIDTH = IDX_WIDTH + 1;

  logic [PTR_WIDTH-1:0]  head_ptr;
  logic [PTR_WIDTH-1:0]  tail_ptr;
  logic [IDX_WIDTH-1:0]  head_idx;
  logic [IDX_WIDTH-1:0]  tail_idx;
  logic [PTR_WIDTH-1:0]  commit_cnt;
  logic [SQ_DEPTH-1:0]   sq_valid;
  logic [SQ_DEPTH-1:0]   sq_exec;
  logic [ADDR_WIDTH-1:0] sq_addr [SQ_DEPTH];
  logic [DATA_WIDTH-1:0] sq_data [SQ_DEPTH];
  logic [IDX_WIDTH-1:0]  fwd_idx;
  logic [PTR_WIDTH-1:0]  older_cnt;
  logic                  alloc;
  logic                  drain_fire;
  drain_state_t          drain_state;
  drain_state_t          drain_next;

  assign head_idx    = head_ptr[IDX_WIDTH-1:0];
  assign tail_idx    = tail_ptr[IDX_WIDTH-1:0];
  assign store_ready = !sq_valid[tail_idx];
  assign sq_idx      = tail_idx;
  assign sq_tail     = tail_ptr;
  assign alloc       = (dispatch_op == MEM_STORE) && store_ready;

  // Head store goes out while committed stores remain
  assign wr_req     = (drain_state == DRAIN_WRITE);
  assign wr_addr    = sq_addr[head_idx];
  assign wr_data    = sq_data[head_idx];
  assign drain_fire = wr_req && wr_grant;

  always_comb begin
    drain_next = drain_state;
    case (drain_state)
      DRAIN_IDLE: begin
        if (retire_store) drain_next = DRAIN_WRITE;
      end
      DRAIN_WRITE: begin
        if (drain_fire && !retire_store && commit_cnt == PTR_WIDTH'(1)) drain_next = DRAIN_IDLE;
      end
      default: drain_next = DRAIN_IDLE;
    endcase
  end

  // Walk back from the load tag toward the head, youngest older store first
  assign older_cnt = fwd_tag - head_ptr;

  always_comb begin
    logic [IDX_WIDTH-1:0] scan_idx;
    fwd_hit  = 1'b0;
    fwd_idx  = '0;
    scan_idx = '0;
    for (int i = 1; i <= SQ_DEPTH; i++) begin
      scan_idx = fwd_tag[IDX_WIDTH-1:0] - IDX_WIDTH'(i);
      if (!fwd_hit && older_cnt <= PTR_WIDTH'(SQ_DEPTH) && PTR_WIDTH'(i) <= older_cnt &&
          sq_valid[scan_idx] && sq_exec[scan_idx] && sq_addr[scan_idx] == fwd_addr) begin
        fwd_hit = 1'b1;
        fwd_idx = scan_idx;
      end
    end
  end

  assign fwd_data = sq_data[fwd_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr    <= '0;
      tail_ptr    <= '0;
      commit_cnt  <= '0;
      sq_valid    <= '0;
      sq_exec     <= '0;
      drain_state <= DRAIN_IDLE;
    end else begin
      drain_state <= drain_next;
      commit_cnt  <= commit_cnt + PTR_WIDTH'(retire_store) - PTR_WIDTH'(drain_fire);
      if (alloc) begin
        sq_valid[tail_idx] <= 1'b1;
        sq_exec[tail_idx]  <= 1'b0;
        tail_ptr           <= tail_ptr + PTR_WIDTH'(1);
      end
      if (store_exec) sq_exec[store_exec_idx] <= 1'b1;
      if (drain_fire) begin
        sq_valid[head_idx] <= 1'b0;
        sq_exec[head_idx]  <= 1'b0;
        head_ptr           <= head_ptr + PTR_WIDTH'(1);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (store_exec) begin
      sq_addr[store_exec_idx] <= store_addr;
      sq_data[store_exec_idx] <= store_data;
    end
  end

endmodule

//--- src/load_queue.sv
`timescale 1ns/1ps

module load_queue #(
  parameter int ADDR_WIDTH = 6,
  parameter int DATA_WIDTH = 32,
  parameter int LQ_DEPTH   = 8,
  parameter int SQ_DEPTH   = 8
) (
  input  logic                          clock,
  input  logic                          reset,
  input  lsq_pkg::mem_op_t              dispatch_op,
  input  logic [$clog2(SQ_DEPTH):0]     sq_tail,
  input  logic                          load_exec,
  input  logic [$clog2(LQ_DEPTH)-1:0]   load_exec_idx,
  input  logic [ADDR_WIDTH-1:0]         load_addr,
  input  logic                          retire_load,
  input  logic                          fwd_hit,
  input  logic [DATA_WIDTH-1:0]         fwd_data,
  input  logic [DATA_WIDTH-1:0]         rd_data,
  output logic                          load_ready,
  output logic [$clog2(LQ_DEPTH)-1:0]   lq_idx,
  output logic [ADDR_WIDTH-1:0]         fwd_addr,
  output logic [$clog2(SQ_DEPTH):0]     fwd_tag,
  output logic                          rd_req,
  output logic [ADDR_WIDTH-1:0]         rd_addr,
  output logic                          load_done,
  output logic [DATA_WIDTH-1:0]         load_data,
  output logic                          load_forwarded
);
  import lsq_pkg::*;

  localparam int IDX_WIDTH = $clog2(LQ_DEPTH);
  localparam int TAG_WIDTH = $clog2(SQ_DEPTH) + 1;

  logic [IDX_WIDTH-1:0]  head;
  logic [IDX_WIDTH-1:0]  tail;
  logic [LQ_DEPTH-1:0]   lq_valid;
  logic [TAG_WIDTH-1:0]  lq_tag [LQ_DEPTH];
  logic                  alloc;
  logic                  done_q;
  logic                  fwd_q;
  logic [DATA_WIDTH-1:0] fwd_data_q;

  assign load_ready = !lq_valid[tail];
  assign lq_idx     = tail;
  assign alloc      = (dispatch_op == MEM_LOAD) && load_ready;

  // Forwarding lookup and memory read share the same execute cycle
  assign fwd_addr = load_addr;
  assign fwd_tag  = lq_tag[load_exec_idx];
  assign rd_req   = load_exec && !fwd_hit;
  assign rd_addr  = load_addr;

  // Memory data arrives one cycle after the read, lined up with done
  assign load_done      = done_q;
  assign load_forwarded = fwd_q;
  assign load_data      = fwd_q ? fwd_data_q : rd_data;

  always_ff @(posedge clock) begin
    if (reset) begin
      head     <= '0;
      tail     <= '0;
      lq_valid <= '0;
      done_q   <= 1'b0;
      fwd_q    <= 1'b0;
    end else begin
      done_q <= load_exec;
      fwd_q  <= load_exec && fwd_hit;
      if (alloc) begin
        lq_valid[tail] <= 1'b1;
        tail           <= tail + IDX_WIDTH'(1);
      end
      if (retire_load && lq_valid[head]) begin
        lq_valid[head] <= 1'b0;
        head           <= head + IDX_WIDTH'(1);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) lq_tag[tail] <= sq_tail;
    fwd_data_q <= fwd_data;
  end

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int ADDR_WIDTH = 6,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  rd_req,
  input  logic [ADDR_WIDTH-1:0] rd_addr,
  input  logic                  wr_req,
  input  logic [ADDR_WIDTH-1:0] wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  output logic                  wr_grant,
  output logic                  mem_we,
  output logic [ADDR_WIDTH-1:0] mem_addr,
  output logic [DATA_WIDTH-1:0] mem_wdata
);

  // Loads always win, so a read never waits
  assign wr_grant = wr_req && !rd_req;
  assign mem_we   = wr_grant;

  always_comb begin
    if (rd_req) begin
      mem_addr = rd_addr;
    end else begin
      mem_addr = wr_addr;
    end
  end

  assign mem_wdata = wr_data;

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int ADDR_WIDTH = 6,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clock,
  input  logic                  mem_we,
  input  logic [ADDR_WIDTH-1:0] mem_addr,
  input  logic [DATA_WIDTH-1:0] mem_wdata,
  output logic [DATA_WIDTH-1:0] rd_data
);

  localparam int WORDS = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [WORDS];

  // Registered read, data valid the cycle after the address
  always_ff @(posedge clock) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    rd_data <= mem[mem_addr];
  end

endmodule

//--- src/lsq_unit.sv
`timescale 1ns/1ps

module lsq_unit #(
  parameter int ADDR_WIDTH = 6,
  parameter int DATA_WIDTH = 32,
  parameter int SQ_DEPTH   = 8,
  parameter int LQ_DEPTH   = 8,
  localparam int IDX_WIDTH = $clog2((SQ_DEPTH > LQ_DEPTH) ? SQ_DEPTH : LQ_DEPTH)
) (
  input  logic                          clock,
  input  logic                          reset,
  input  lsq_pkg::mem_op_t              dispatch_op,
  input  logic                          store_exec,
  input  logic [$clog2(SQ_DEPTH)-1:0]   store_exec_idx,
  input  logic [ADDR_WIDTH-1:0]         store_addr,
  input  logic [DATA_WIDTH-1:0]         store_data,
  input  logic                          load_exec,
  input  logic [$clog2(LQ_DEPTH)-1:0]   load_exec_idx,
  input  logic [ADDR_WIDTH-1:0]         load_addr,
  input  logic                          retire_store,
  input  logic                          retire_load,
  output logic                          store_ready,
  output logic                          load_ready,
  output logic [IDX_WIDTH-1:0]          dispatch_idx,
  output logic                          load_done,
  output logic [DATA_WIDTH-1:0]         load_data,
  output logic                          load_forwarded
);
  import lsq_pkg::*;

  logic [$clog2(SQ_DEPTH)-1:0] sq_idx;
  logic [$clog2(LQ_DEPTH)-1:0] lq_idx;
  logic [$clog2(SQ_DEPTH):0]   sq_tail;
  logic [$clog2(SQ_DEPTH):0]   fwd_tag;
  logic [ADDR_WIDTH-1:0]       fwd_addr;
  logic                        fwd_hit;
  logic [DATA_WIDTH-1:0]       fwd_data;
  logic                        rd_req;
  logic [ADDR_WIDTH-1:0]       rd_addr;
  logic [DATA_WIDTH-1:0]       rd_data;
  logic                        wr_req;
  logic                        wr_grant;
  logic [ADDR_WIDTH-1:0]       wr_addr;
  logic [DATA_WIDTH-1:0]       wr_data;
  logic                        mem_we;
  logic [ADDR_WIDTH-1:0]       mem_addr;
  logic [DATA_WIDTH-1:0]       mem_wdata;

  // Report the slot of whichever queue took this dispatch
  always_comb begin
    case (dispatch_op)
      MEM_STORE: dispatch_idx = IDX_WIDTH'(sq_idx);
      default:   dispatch_idx = IDX_WIDTH'(lq_idx);
    endcase
  end

  store_queue #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .SQ_DEPTH   (SQ_DEPTH)
  ) u_store_queue (
    .clock          (clock),
    .reset          (reset),
    .dispatch_op    (dispatch_op),
    .store_exec     (store_exec),
    .store_exec_idx (store_exec_idx),
    .store_addr     (store_addr),
    .store_data     (store_data),
    .retire_store   (retire_store),
    .fwd_addr       (fwd_addr),
    .fwd_tag        (fwd_tag),
    .wr_grant       (wr_grant),
    .store_ready    (store_ready),
    .sq_idx         (sq_idx),
    .sq_tail        (sq_tail),
    .fwd_hit        (fwd_hit),
    .fwd_data       (fwd_data),
    .wr_req         (wr_req),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data)
  );

  load_queue #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .LQ_DEPTH   (LQ_DEPTH),
    .SQ_DEPTH   (SQ_DEPTH)
  ) u_load_queue (
    .clock          (clock),
    .reset          (reset),
    .dispatch_op    (dispatch_op),
    .sq_tail        (sq_tail),
    .load_exec      (load_exec),
    .load_exec_idx  (load_exec_idx),
    .load_addr      (load_addr),
    .retire_load    (retire_load),
    .fwd_hit        (fwd_hit),
    .fwd_data       (fwd_data),
    .rd_data        (rd_data),
    .load_ready     (load_ready),
    .lq_idx         (lq_idx),
    .fwd_addr       (fwd_addr),
    .fwd_tag        (fwd_tag),
    .rd_req         (rd_req),
    .rd_addr        (rd_addr),
    .load_done      (load_done),
    .load_data      (load_data),
    .load_forwarded (load_forwarded)
  );

  mem_arbiter #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_mem_arbiter (
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .wr_req    (wr_req),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_grant  (wr_grant),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata)
  );

  data_ram #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_data_ram (
    .clock     (clock),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .rd_data   (rd_data)
  );

endmodule

//--- verification/lsq_unit_props.sv
`timescale 1ns/1ps

module lsq_unit_props (
  input logic                  clock,
  input logic                  reset,
  input logic                  load_exec,
  input logic                  load_done,
  input logic                  rd_req,
  input logic                  wr_req,
  input logic                  wr_grant,
  input lsq_pkg::drain_state_t drain_state
);
  import lsq_pkg::*;

  // Result pulse lands exactly one cycle after the execute strobe
  assert property (@(posedge clock) disable iff (reset) load_exec |=> load_done)
    else $error("load_done did not follow load_exec by one cycle");

  assert property (@(posedge clock) disable iff (reset) load_done |-> $past(load_exec))
    else $error("load_done rose without a load_exec one cycle earlier");

  // Nothing pending once reset has been applied
  assert property (@(posedge clock)
      reset |=> !load_done && !wr_req && drain_state == DRAIN_IDLE)
    else $error("load_done, wr_req or drain state not cleared by reset");

  // Reads own the memory port
  assert property (@(posedge clock) disable iff (reset) !(wr_grant && rd_req))
    else $error("wr_grant high while rd_req is high");

endmodule

bind lsq_unit lsq_unit_props u_props (
  .clock       (clock),
  .reset       (reset),
  .load_exec   (load_exec),
  .load_done   (load_done),
  .rd_req      (rd_req),
  .wr_req      (wr_req),
  .wr_grant    (wr_grant),
  .drain_state (u_store_queue.drain_state)
);

//--- verification/lsq_unit_tb.sv
`timescale 1ns/1ps

module lsq_unit_tb;
  import lsq_pkg::*;

  localparam int ADDR_WIDTH = 6;
  localparam int DATA_WIDTH = 32;
  localparam int SQ_DEPTH   = 8;
  localparam int LQ_DEPTH   = 8;
  localparam int SQ_IDX     = $clog2(SQ_DEPTH);
  localparam int LQ_IDX     = $clog2(LQ_DEPTH);
  localparam int IDX_WIDTH  = $clog2((SQ_DEPTH > LQ_DEPTH) ? SQ_DEPTH : LQ_DEPTH);
  // Per-test cycle budgets plus a margin
  localparam int RUN_CYCLES = 10 + 300 + 40 + 40 + 60 + 80 + 100;

  logic                  clock;
  logic                  reset;
  mem_op_t               dispatch_op;
  logic                  store_exec;
  logic [SQ_IDX-1:0]     store_exec_idx;
  logic [ADDR_WIDTH-1:0] store_addr;
  logic [DATA_WIDTH-1:0] store_data;
  logic                  load_exec;
  logic [LQ_IDX-1:0]     load_exec_idx;
  logic [ADDR_WIDTH-1:0] load_addr;
  logic                  retire_store;
  logic                  retire_load;
  logic                  store_ready;
  logic                  load_ready;
  logic [IDX_WIDTH-1:0]  dispatch_idx;
  logic                  load_done;
  logic [DATA_WIDTH-1:0] load_data;
  logic                  load_forwarded;

  // Reference memory plus in-flight stores with the oldest at index 0
  logic [DATA_WIDTH-1:0] ref_mem [1 << ADDR_WIDTH];
  logic [ADDR_WIDTH-1:0] st_addr [$];
  logic [DATA_WIDTH-1:0] st_data [$];
  bit                    st_exec_q [$];
  int                    st_issued;
  int                    st_retired;
  int                    st_drained;
  int                    ld_issued;
  int                    ld_retired;
  int                    ld_tag [LQ_DEPTH];
  logic [DATA_WIDTH-1:0] exp_data;
  logic                  exp_fwd;
  logic [DATA_WIDTH-1:0] exp_data_d;
  logic                  exp_fwd_d;
  logic [31:0]           rng;
  int                    errors;
  int                    loads_checked;
  int                    tests_run;

  lsq_unit #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .SQ_DEPTH   (SQ_DEPTH),
    .LQ_DEPTH   (LQ_DEPTH)
  ) u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin
    repeat (RUN_CYCLES) @(posedge clock);
    $display("Watchdog expired after %0d cycles", RUN_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  // Expectation lines up with load_done one cycle after the strobe
  always @(posedge clock) begin
    exp_data_d <= exp_data;
    exp_fwd_d  <= exp_fwd;
  end

  assert property (@(posedge clock) disable iff (reset) load_done |-> load_data === exp_data_d)
    else begin
      $display("Mismatch load_data: got %h expected %h", $sampled(load_data),
               $sampled(exp_data_d));
      errors++;
    end

  assert property (@(posedge clock) disable iff (reset)
      load_done |-> load_forwarded === exp_fwd_d)
    else begin
      $display("Mismatch load_forwarded: got %h expected %h", $sampled(load_forwarded),
               $sampled(exp_fwd_d));
      errors++;
    end

  // A granted drain moves the oldest model store into the reference memory
  always @(negedge clock) begin
    if (!reset && u_dut.wr_grant) begin
      if (st_addr.size() == 0 || st_drained >= st_retired) begin
        $display("Drain write granted with no committed store waiting");
        errors++;
      end else begin
        ref_mem[st_addr[0]] = st_data[0];
        st_addr.delete(0);
        st_data.delete(0);
        st_exec_q.delete(0);
        st_drained++;
      end
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Strobes last one cycle
  task automatic step();
    @(posedge clock);
    dispatch_op  <= MEM_NONE;
    store_exec   <= 1'b0;
    load_exec    <= 1'b0;
    retire_store <= 1'b0;
    retire_load  <= 1'b0;
  endtask

  task automatic dispatch_store(output int seq);
    logic exp_ready;
    step();
    exp_ready = (st_issued - st_drained) < SQ_DEPTH;
    seq = exp_ready ? st_issued : -1;
    dispatch_op <= MEM_STORE;
    if (exp_ready) begin
      st_addr.push_back('0);
      st_data.push_back('0);
      st_exec_q.push_back(1'b0);
      st_issued++;
    end
    @(negedge clock);
    check_value("store_ready", 32'(store_ready), 32'(exp_ready));
    if (exp_ready) check_value("dispatch_idx", 32'(dispatch_idx), seq % SQ_DEPTH);
  endtask

  task automatic exec_store(input int seq, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] data);
    int pos;
    step();
    pos = seq - st_drained;
    st_addr[pos]   = addr;
    st_data[pos]   = data;
    st_exec_q[pos] = 1'b1;
    store_exec     <= 1'b1;
    store_exec_idx <= SQ_IDX'(seq);
    store_addr     <= addr;
    store_data     <= data;
  endtask

  task automatic commit_store();
    step();
    retire_store <= 1'b1;
    st_retired++;
  endtask

  task automatic dispatch_load(output int slot);
    step();
    slot = ld_issued % LQ_DEPTH;
    ld_tag[slot] = st_issued;
    dispatch_op <= MEM_LOAD;
    ld_issued++;
    @(negedge clock);
    check_value("load_ready", 32'(load_ready), 32'd1);
    check_value("dispatch_idx", 32'(dispatch_idx), slot);
  endtask

  // Called right after step so it can share a cycle with other strobes
  task automatic issue_load(input int slot, input logic [ADDR_WIDTH-1:0] addr);
    logic [DATA_WIDTH-1:0] data;
    logic                  fwd;
    int                    pos;
    data = ref_mem[addr];
    fwd  = 1'b0;
    pos  = ld_tag[slot] - st_drained - 1;
    // Youngest older executed store to the same word
    while (pos >= 0 && !fwd) begin
      if (st_exec_q[pos] && st_addr[pos] == addr) begin
        fwd  = 1'b1;
        data = st_data[pos];
      end
      pos--;
    end
    exp_data      <= data;
    exp_fwd       <= fwd;
    load_exec     <= 1'b1;
    load_exec_idx <= LQ_IDX'(slot);
    load_addr     <= addr;
    loads_checked++;
  endtask

  task automatic wait_load();
    int n;
    n = 0;
    step();
    do begin
      @(negedge clock);
      n++;
    end while (!load_done && n < 4);
    if (!load_done) begin
      $display("Load result did not arrive within 4 cycles");
      errors++;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    step();
    while (st_drained < st_retired && n < 4 * SQ_DEPTH) begin
      step();
      n++;
    end
    if (st_drained < st_retired) begin
      $display("Committed stores did not drain within %0d cycles", 4 * SQ_DEPTH);
      errors++;
    end
  endtask

  task automatic retire_loads();
    while (ld_retired < ld_issued) begin
      step();
      retire_load <= 1'b1;
      ld_retired++;
    end
  endtask

  task automatic report(input string name, input int errors_before);
    @(negedge clock);
    tests_run++;
    $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_before);
  endtask

  initial begin
    int                    mark;
    int                    i;
    int                    s0;
    int                    s1;
    int                    slot;
    int                    seqs [SQ_DEPTH + 2];
    int                    slots [6];
    logic [ADDR_WIDTH-1:0] base;
    rng            = 32'h7ab0;
    errors         = 0;
    loads_checked  = 0;
    tests_run      = 0;
    st_issued      = 0;
    st_retired     = 0;
    st_drained     = 0;
    ld_issued      = 0;
    ld_retired     = 0;
    exp_data       = '0;
    exp_fwd        = 1'b0;
    reset          = 1'b1;
    dispatch_op    = MEM_NONE;
    store_exec     = 1'b0;
    store_exec_idx = '0;
    store_addr     = '0;
    store_data     = '0;
    load_exec      = 1'b0;
    load_exec_idx  = '0;
    load_addr      = '0;
    retire_store   = 1'b0;
    retire_load    = 1'b0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    mark = errors;
    @(negedge clock);
    check_value("store_ready", 32'(store_ready), 32'd1);
    check_value("load_ready", 32'(load_ready), 32'd1);
    check_value("load_done", 32'(load_done), 32'd0);
    report("reset", mark);

    // Every word gets written through the store path before any read
    mark = errors;
    for (i = 0; i < (1 << ADDR_WIDTH); i++) begin
      dispatch_store(s0);
      exec_store(s0, ADDR_WIDTH'(i), next_rand());
      commit_store();
    end
    wait_drain();
    for (i = 0; i < 4; i++) begin
      dispatch_load(slot);
      step();
      issue_load(slot, ADDR_WIDTH'(next_rand()));
      wait_load();
    end
    retire_loads();
    report("memory path", mark);

    mark = errors;
    base = ADDR_WIDTH'(next_rand());
    dispatch_store(s0);
    dispatch_store(s1);
    exec_store(s0, base, next_rand());
    exec_store(s1, base, next_rand());
    dispatch_load(slot);
    step();
    issue_load(slot, base);
    wait_load();
    commit_store();
    commit_store();
    wait_drain();
    retire_loads();
    report("youngest older store", mark);

    // Load is older than the store, so it must read memory
    mark = errors;
    base = ADDR_WIDTH'(next_rand());
    dispatch_load(slot);
    dispatch_store(s0);
    exec_store(s0, base, next_rand());
    step();
    issue_load(slot, base);
    wait_load();
    commit_store();
    wait_drain();
    retire_loads();
    report("age ordering", mark);

    mark = errors;
    for (i = 0; i < SQ_DEPTH + 2; i++) dispatch_store(seqs[i]);
    for (i = 0; i < SQ_DEPTH; i++) exec_store(seqs[i], ADDR_WIDTH'(next_rand()), next_rand());
    for (i = 0; i < SQ_DEPTH; i++) commit_store();
    wait_drain();
    @(negedge clock);
    check_value("store_ready", 32'(store_ready), 32'd1);
    report("full store queue", mark);

    mark = errors;
    base = ADDR_WIDTH'(next_rand());
    for (i = 0; i < 3; i++) dispatch_store(seqs[i]);
    for (i = 0; i < 3; i++) exec_store(seqs[i], base + ADDR_WIDTH'(i), next_rand());
    for (i = 0; i < 6; i++) dispatch_load(slots[i]);
    // A read every cycle keeps the committed stores waiting
    for (i = 0; i < 6; i++) begin
      step();
      issue_load(slots[i], base + ADDR_WIDTH'(8 + i));
      if (i < 3) begin
        retire_store <= 1'b1;
        st_retired++;
      end
    end
    wait_load();
    wait_drain();
    retire_loads();
    for (i = 0; i < 3; i++) begin
      dispatch_load(slot);
      step();
      issue_load(slot, base + ADDR_WIDTH'(i));
      wait_load();
    end
    retire_loads();
    report("contention", mark);

    $display("Tests run %0d, loads checked %0d, errors %0d", tests_run, loads_checked, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- lsq_unit.f
src/lsq_pkg.sv
src/store_queue.sv
src/load_queue.sv
src/mem_arbiter.sv
src/data_ram.sv
src/lsq_unit.sv
verification/lsq_unit_props.sv
verification/lsq_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f lsq_unit.f --top-module lsq_unit_tb -Mdir obj_dir
./obj_dir/Vlsq_unit_tb > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0
